// ==== sim.f ====
logic/mm_pkg.sv
logic/mm_wave_if.sv
logic/mm_ctrl.sv
logic/mm_operand_loader.sv
logic/mm_skew_feeder.sv
logic/mm_pe_array.sv
logic/mm_result_drain.sv
logic/mm_top.sv
dv/mm_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the matrix multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module mm_tb -f sim.f -o mm_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/mm_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== dv/mm_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module mm_tb;
    import mm_pkg::*;

    localparam int WORD_W       = $bits(in_word_t);
    localparam int VEC_W        = WORD_W / 2;
    localparam int ROW_W        = $bits(res_word_t);
    localparam int MAT_W        = MM_N * WORD_W;
    localparam int PROD_W       = MM_N * ROW_W;
    localparam int RESET_CYCLES = 10;
    localparam int N_RANDOM     = 20;
    localparam int N_CORNER     = 3;
    localparam int N_GAP        = 10;
    localparam int N_STALL      = 10;
    localparam int N_MIXED      = 8;
    localparam int N_TOTAL      = N_RANDOM + N_CORNER + N_GAP + N_STALL + N_MIXED;
    localparam int GAP_MAX      = 5;
    localparam int MAX_STALL    = 4;  // Longest run of res_ready low
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20 + 40 * N_TOTAL
                                   + (N_GAP + N_MIXED) * MM_N * GAP_MAX
                                   + (N_STALL + N_MIXED) * MM_N * MAX_STALL;

    logic clk;
    logic rst;
    logic in_valid;
    logic in_ready;
    in_word_t in_data;
    logic res_valid;
    logic res_ready;
    res_word_t res_data;

    integer seed;
    logic stall_on;
    int stall_run;
    int matrices_sent;
    int rows_checked;
    int row_idx;
    logic held_valid;
    res_word_t held_data;
    logic [PROD_W-1:0] cur_exp;
    logic [PROD_W-1:0] exp_q [$];  // Expected C per sent matrix
    mm_state_t dut_state;
    mm_state_t prev_state;

    mm_top u_mm_top (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data)
    );

    assign dut_state = u_mm_top.u_ctrl.state;

    always #20 clk = ~clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on failure");
    endtask

    task automatic check_value(input string name, input res_word_t actual,
                               input res_word_t expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Error: time %0t, %s = 0x%h, expected 0x%h",
                                        $time, name, actual, expected));
        end
    endtask

    // C[i][j] = sum over k of A[i][k] * B[k][j]
    function automatic logic [PROD_W-1:0] ref_product(input logic [MAT_W-1:0] words);
        logic [PROD_W-1:0] c;
        int sum;
        int a_elem;
        int b_elem;
        c = '0;
        for (int i = 0; i < MM_N; i++) begin
            for (int j = 0; j < MM_N; j++) begin
                sum = 0;
                for (int k = 0; k < MM_N; k++) begin
                    a_elem = int'(words[i * WORD_W + VEC_W + k * ELEM_W +: ELEM_W]);
                    b_elem = int'(words[j * WORD_W + k * ELEM_W +: ELEM_W]);  // Column j
                    sum += a_elem * b_elem;
                end
                c[i * ROW_W + j * ACC_W +: ACC_W] = sum[ACC_W-1:0];
            end
        end
        return c;
    endfunction

    function automatic logic [MAT_W-1:0] random_matrix();
        logic [MAT_W-1:0] words;
        for (int w = 0; w < MM_N; w++) begin
            words[w * WORD_W +: WORD_W] = {$random(seed), $random(seed)};
        end
        return words;
    endfunction

    task automatic send_word(input in_word_t w, input int gap_max);
        int gap;
        gap = 0;
        if (gap_max > 0) begin
            gap = $unsigned($random(seed)) % (gap_max + 1);
        end
        if (gap > 0) begin
            in_valid <= 1'b0;
            repeat (gap) @(posedge clk);
        end
        in_valid <= 1'b1;
        in_data  <= w;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);  // Held until taken
        end
    endtask

    task automatic send_matrix(input logic [MAT_W-1:0] words, input int gap_max);
        exp_q.push_back(ref_product(words));
        matrices_sent++;
        for (int w = 0; w < MM_N; w++) begin
            send_word(words[w * WORD_W +: WORD_W], gap_max);
        end
    endtask

    initial begin
        logic [MAT_W-1:0] words;
        clk           = 1'b0;
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_data       = '0;
        seed          = 92;
        stall_on      = 1'b0;
        matrices_sent = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);  // Idle, nothing may come out

        for (int m = 0; m < N_RANDOM; m++) begin
            send_matrix(random_matrix(), 0);
        end

        send_matrix('1, 0);  // Every element 255
        words = random_matrix();
        for (int w = 0; w < MM_N; w++) begin
            words[w * WORD_W + VEC_W +: VEC_W] = 32'(1) << (ELEM_W * w);  // Identity A
        end
        send_matrix(words, 0);
        send_matrix('0, 0);

        for (int m = 0; m < N_GAP; m++) begin
            send_matrix(random_matrix(), GAP_MAX);
        end

        stall_on = 1'b1;
        for (int m = 0; m < N_STALL; m++) begin
            send_matrix(random_matrix(), 0);
        end
        for (int m = 0; m < N_MIXED; m++) begin
            send_matrix(random_matrix(), GAP_MAX);
        end
        in_valid <= 1'b0;

        while (rows_checked < N_TOTAL * MM_N) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);  // Catch stray extra rows
        if (in_ready && !res_valid) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            stop_with_failure("DUT did not return to the load phase after the last matrix");
        end
    end

    // Output back-pressure
    initial begin
        res_ready = 1'b1;
        stall_run = 0;
        forever begin
            @(posedge clk);
            if (stall_on && stall_run < MAX_STALL && $random(seed) % 2 == 0) begin
                res_ready <= 1'b0;
                stall_run++;
            end else begin
                res_ready <= 1'b1;
                stall_run = 0;
            end
        end
    end

    initial begin
        rows_checked = 0;
        row_idx      = 0;
        held_valid   = 1'b0;
        held_data    = '0;
        cur_exp      = '0;
        prev_state   = ST_LOAD;
    end

    always @(posedge clk) begin
        if (rst) begin
            check_value("res_valid", res_word_t'(res_valid), '0);
            check_value("in_ready", res_word_t'(in_ready), res_word_t'(1));
        end else begin
            check_value("in_ready && res_valid", res_word_t'(in_ready && res_valid), '0);
            if (matrices_sent == 0) begin
                check_value("in_ready", res_word_t'(in_ready), res_word_t'(1));
            end
            if (held_valid) begin
                check_value("res_valid", res_word_t'(res_valid), res_word_t'(1));
                check_value("res_data", res_data, held_data);  // Stable under stall
            end
            if (res_valid && res_ready) begin
                if (row_idx == 0 && exp_q.size() == 0) begin
                    stop_with_failure("Result row arrived with no matrix outstanding");
                end else begin
                    if (row_idx == 0) begin
                        cur_exp = exp_q.pop_front();
                    end
                    check_value($sformatf("res_data row %0d", row_idx), res_data,
                                cur_exp[row_idx * ROW_W +: ROW_W]);
                    rows_checked++;
                    row_idx = (row_idx + 1) % MM_N;
                end
            end
            held_valid = res_valid && !res_ready;
            held_data  = res_data;
            if (dut_state != prev_state && dut_state == ST_DRAIN) begin
                $display("[%0t] state %s, %0d rows checked", $time, dut_state.name(),
                         rows_checked);
            end
            prev_state = dut_state;
        end
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_failure("Timeout: not all result rows arrived within the cycle budget");
    end

endmodule

`default_nettype wire

// ==== logic/mm_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mm_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  mm_pkg::in_word_t  in_data,
    output logic              res_valid,
    input  logic              res_ready,
    output mm_pkg::res_word_t res_data
);
    import mm_pkg::*;

    logic load_en;
    logic load_done;
    logic start;
    logic feed_done;
    logic drain_en;
    logic drain_done;
    vec_t a_rows [MM_N];
    vec_t b_cols [MM_N];
    acc_t acc [MM_N][MM_N];

    mm_wave_if u_wave ();

    assign in_ready = load_en;

    mm_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .load_done  (load_done),
        .feed_done  (feed_done),
        .drain_done (drain_done),
        .load_en    (load_en),
        .start      (start),
        .drain_en   (drain_en)
    );

    mm_operand_loader u_loader (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .load_done (load_done),
        .a_rows    (a_rows),
        .b_cols    (b_cols)
    );

    mm_skew_feeder u_feeder (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .a_rows    (a_rows),
        .b_cols    (b_cols),
        .feed_done (feed_done),
        .wave      (u_wave)
    );

    mm_pe_array u_array (
        .clk  (clk),
        .rst  (rst),
        .wave (u_wave),
        .acc  (acc)
    );

    mm_result_drain u_drain (
        .clk        (clk),
        .rst        (rst),
        .drain_en   (drain_en),
        .acc        (acc),
        .res_ready  (res_ready),
        .res_valid  (res_valid),
        .res_data   (res_data),
        .drain_done (drain_done)
    );

endmodule

`default_nettype wire

// ==== logic/mm_result_drain.sv ====
`timescale 1ns/100ps
`default_nettype none

module mm_result_drain (
    input  logic              clk,
    input  logic              rst,
    input  logic              drain_en,
    input  mm_pkg::acc_t      acc [mm_pkg::MM_N][mm_pkg::MM_N],
    input  logic              res_ready,
    output logic              res_valid,
    output mm_pkg::res_word_t res_data,
    output logic              drain_done
);
    import mm_pkg::*;

    logic [$clog2(MM_N)-1:0] row;
    logic [$clog2(MM_N)-1:0] row_sel;
    logic fire;
    logic load_row;
    res_word_t row_word;

    assign fire     = res_valid && res_ready;
    assign row_sel  = fire ? row + 1'b1 : row;
    // Next row on a handshake, first row when the drain opens
    assign load_row = fire ? (row != MM_N - 1) : (drain_en && !res_valid && !drain_done);

    always_comb begin
        for (int j = 0; j < MM_N; j++) begin
            row_word[j*ACC_W +: ACC_W] = acc[row_sel][j];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            row        <= '0;
            res_valid  <= 1'b0;
            drain_done <= 1'b0;
        end else begin
            drain_done <= 1'b0;
            if (fire) begin
                if (row == MM_N - 1) begin
                    row        <= '0;
                    res_valid  <= 1'b0;
                    drain_done <= 1'b1;
                end else begin
                    row <= row + 1'b1;
                end
            end else if (load_row) begin
                res_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_row) begin
            res_data <= row_word;  // Held while stalled
        end
    end

endmodule

`default_nettype wire

// ==== logic/mm_pe_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module mm_pe_array (
    input  logic         clk,
    input  logic         rst,
    mm_wave_if.dst       wave,
    output mm_pkg::acc_t acc [mm_pkg::MM_N][mm_pkg::MM_N]
);
    import mm_pkg::*;

    logic valid_q;  // Forwarding registers hold current data
    elem_t a_fwd [MM_N][MM_N];
    elem_t b_fwd [MM_N][MM_N];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= wave.wave_valid;
        end
    end

    genvar i, j;
    for (i = 0; i < MM_N; i++) begin : g_row
        for (j = 0; j < MM_N; j++) begin : g_col
            elem_t a_in;
            elem_t b_in;

            if (j == 0) begin : g_a_edge
                assign a_in = wave.a_west[i];
            end else begin : g_a_inner
                // Stale operands from the previous matrix are masked
                assign a_in = valid_q ? a_fwd[i][j-1] : '0;
            end

            if (i == 0) begin : g_b_edge
                assign b_in = wave.b_north[j];
            end else begin : g_b_inner
                assign b_in = valid_q ? b_fwd[i-1][j] : '0;
            end

            always_ff @(posedge clk) begin
                if (wave.wave_valid) begin
                    a_fwd[i][j] <= a_in;  // East
                    b_fwd[i][j] <= b_in;  // South
                end
            end

            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    acc[i][j] <= '0;
                end else if (wave.wave_valid) begin
                    acc[i][j] <= (wave.acc_clear ? acc_t'(0) : acc[i][j]) + a_in * b_in;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/mm_skew_feeder.sv ====
`timescale 1ns/100ps
`default_nettype none

module mm_skew_feeder (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  mm_pkg::vec_t a_rows [mm_pkg::MM_N],
    input  mm_pkg::vec_t b_cols [mm_pkg::MM_N],
    output logic         feed_done,
    mm_wave_if.src       wave
);
    import mm_pkg::*;

    localparam int STEP_W = $clog2(FEED_STEPS);
    typedef logic [STEP_W-1:0] step_t;

    step_t step;  // Rests at zero while idle
    logic busy;
    logic issue;
    elem_t a_next [MM_N];
    elem_t b_next [MM_N];

    assign issue = start || busy;

    // Row i and column i lag by i steps, zero outside the matrix
    always_comb begin
        int k;
        for (int i = 0; i < MM_N; i++) begin
            k = int'(step) - i;
            a_next[i] = '0;
            b_next[i] = '0;
            if (k >= 0 && k < MM_N) begin
                a_next[i] = a_rows[i][k*ELEM_W +: ELEM_W];
                b_next[i] = b_cols[i][k*ELEM_W +: ELEM_W];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy            <= 1'b0;
            step            <= '0;
            wave.wave_valid <= 1'b0;
            wave.acc_clear  <= 1'b0;
            feed_done       <= 1'b0;
        end else begin
            wave.wave_valid <= issue;
            wave.acc_clear  <= start;
            feed_done       <= wave.wave_valid && !issue;  // Cycle after last wavefront
            if (issue) begin
                if (step == step_t'(FEED_STEPS - 1)) begin
                    busy <= 1'b0;
                    step <= '0;
                end else begin
                    busy <= 1'b1;
                    step <= step + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            wave.a_west  <= a_next;
            wave.b_north <= b_next;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mm_operand_loader.sv ====
`timescale 1ns/100ps
`default_nettype none

module mm_operand_loader (
    input  logic             clk,
    input  logic             rst,
    input  logic             load_en,
    input  logic             in_valid,
    input  mm_pkg::in_word_t in_data,
    output logic             load_done,
    output mm_pkg::vec_t     a_rows [mm_pkg::MM_N],
    output mm_pkg::vec_t     b_cols [mm_pkg::MM_N]
);
    import mm_pkg::*;

    localparam int VEC_W = $bits(vec_t);

    logic [$clog2(MM_N)-1:0] word_cnt;
    logic accept;
    vec_t row_word;
    vec_t col_word;

    assign accept   = in_valid && load_en;
    assign row_word = in_data[VEC_W +: VEC_W];
    assign col_word = in_data[0 +: VEC_W];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            word_cnt  <= '0;
            load_done <= 1'b0;
            for (int w = 0; w < MM_N; w++) begin
                a_rows[w] <= '0;
                b_cols[w] <= '0;
            end
        end else begin
            load_done <= 1'b0;
            if (accept) begin
                a_rows[word_cnt] <= row_word;  // Row w of A
                b_cols[word_cnt] <= col_word;  // Column w of B
                if (word_cnt == MM_N - 1) begin
                    word_cnt  <= '0;
                    load_done <= 1'b1;
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/mm_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module mm_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic load_done,
    input  logic feed_done,
    input  logic drain_done,
    output logic load_en,
    output logic start,
    output logic drain_en
);
    import mm_pkg::*;

    mm_state_t state;
    mm_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            ST_LOAD: begin
                if (load_done) begin
                    state_next = ST_COMPUTE;
                end
            end
            ST_COMPUTE: begin
                if (feed_done) begin
                    state_next = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                if (drain_done) begin
                    state_next = ST_LOAD;
                end
            end
            default: begin
                state_next = ST_LOAD;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_LOAD;
            start <= 1'b0;
        end else begin
            state <= state_next;
            start <= (state == ST_LOAD) && (state_next == ST_COMPUTE);  // Single pulse
        end
    end

    // load_done is a registered pulse, so the word after the fourth is refused
    assign load_en  = (state == ST_LOAD) && !load_done;
    assign drain_en = (state == ST_DRAIN);

endmodule

`default_nettype wire

// ==== logic/mm_wave_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface mm_wave_if;
    import mm_pkg::*;

    elem_t a_west [MM_N];   // One per array row
    elem_t b_north [MM_N];  // One per array column
    logic wave_valid;
    logic acc_clear;        // Comes with the first wavefront

    modport src (
        output a_west,
        output b_north,
        output wave_valid,
        output acc_clear
    );

    modport dst (
        input a_west,
        input b_north,
        input wave_valid,
        input acc_clear
    );

endinterface

`default_nettype wire

// ==== logic/mm_pkg.sv ====
`default_nettype none

package mm_pkg;

    localparam int MM_N       = 4;
    localparam int ELEM_W     = 8;
    localparam int ACC_W      = 18;  // Holds 4 * 255 * 255 without overflow
    localparam int FEED_STEPS = 3 * MM_N - 2;

    typedef logic [ELEM_W-1:0] elem_t;
    typedef logic [ACC_W-1:0] acc_t;

    // Element k at byte k
    typedef logic [MM_N*ELEM_W-1:0] vec_t;

    // Upper half A row, lower half B column
    typedef logic [2*MM_N*ELEM_W-1:0] in_word_t;

    // Element j at bits ACC_W*j upward
    typedef logic [MM_N*ACC_W-1:0] res_word_t;

    typedef enum logic [1:0] {
        ST_LOAD,
        ST_COMPUTE,
        ST_DRAIN
    } mm_state_t;

endpackage

`default_nettype wire
